/* systolic_matmul.f */
+incdir+.
systolic_pkg.sv
mac_sequencer.sv
operand_skew.sv
processing_element.sv
pe_array.sv
result_drain.sv
matmul_4x4_systolic.sv
tb_matmul_4x4_systolic_sva.sv
tb_matmul_4x4_systolic.sv

/* run_sim.sh */
#!/bin/sh
# build and run the testbench with Verilator, then scan the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f systolic_matmul.f \
  --top-module tb_matmul_4x4_systolic -o tb_sim

./obj_dir/tb_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "SOME TESTS FAILED" sim.log; then
  echo "simulation reported a failure"
  exit 1
fi
if ! grep -q "ALL TESTS PASSED" sim.log; then
  echo "simulation did not complete"
  exit 1
fi

/* tb_matmul_4x4_systolic.sv */
`timescale 1ns/1ps
`include "systolic_macros.svh"

module tb_matmul_4x4_systolic
  import systolic_pkg::*;
();

  typedef elem_t [`MAT_SIZE-1:0][`MAT_SIZE-1:0] mat_t;

  // one table row: operands and the expected product
  typedef struct packed {
    mat_t a;
    mat_t b;
    mat_t c;
  } mat_case_t;

  localparam int NUM_CASES    = 8;
  localparam int DONE_COUNT   = `LATCH_CYCLE + 1;
  localparam int DONE_TIMEOUT = 32;
  localparam int DRAIN_CYCLES = 2 * `MAT_SIZE;

  logic        clk = 1'b0;
  logic        reset;
  logic        start_mat_mul;
  lane_vec_t   a_data;
  lane_vec_t   b_data;
  addr_t       a_addr;
  addr_t       b_addr;
  lane_vec_t   c_data;
  logic        done_mat_mul;
  mat_case_t   cases [NUM_CASES];
  mat_case_t   cur_case;
  logic [31:0] lfsr_state;

  matmul_4x4_systolic dut (
    .clk           (clk),
    .reset         (reset),
    .start_mat_mul (start_mat_mul),
    .a_data        (a_data),
    .b_data        (b_data),
    .a_addr        (a_addr),
    .b_addr        (b_addr),
    .c_data        (c_data),
    .done_mat_mul  (done_mat_mul)
  );

  always #20 clk = ~clk;

  // async operand memories, A column and B row, zero above MAT_SIZE
  always_comb begin
    a_data = '0;
    b_data = '0;
    for (int i = 0; i < `MAT_SIZE; i++) begin
      if (a_addr < addr_t'(`MAT_SIZE)) begin
        a_data[i*`ELEM_WIDTH +: `ELEM_WIDTH] = cur_case.a[i][a_addr[1:0]];
      end
      if (b_addr < addr_t'(`MAT_SIZE)) begin
        b_data[i*`ELEM_WIDTH +: `ELEM_WIDTH] = cur_case.b[b_addr[1:0]][i];
      end
    end
  end

  ////////////////////
  // reference model
  ////////////////////

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h80200003;
    end
    return s >> 1;
  endfunction

  // one LFSR step per bit
  task automatic random_elem(output elem_t e);
    int n;
    e = '0;
    for (n = 0; n < `ELEM_WIDTH; n++) begin
      lfsr_state = lfsr_step(lfsr_state);
      e = {e[`ELEM_WIDTH-2:0], lfsr_state[0]};
    end
  endtask

  function automatic mat_t reference_product(input mat_t a, input mat_t b);
    mat_t  c;
    elem_t sum;
    int    i;
    int    j;
    int    k;
    for (i = 0; i < `MAT_SIZE; i++) begin
      for (j = 0; j < `MAT_SIZE; j++) begin
        sum = '0;
        for (k = 0; k < `MAT_SIZE; k++) begin
          sum = sum + elem_t'(a[i][k] * b[k][j]);
        end
        c[i][j] = sum;
      end
    end
    return c;
  endfunction

  // lane r shows C[r][m-r] m cycles after done rises
  function automatic elem_t drain_expect(input mat_t c, input int r, input int m);
    if (m - r >= 0 && m - r < `MAT_SIZE) begin
      return c[r][m-r];
    end
    return '0;
  endfunction

  task automatic build_cases();
    int n;
    int i;
    int j;
    for (n = 0; n < NUM_CASES; n++) begin
      for (i = 0; i < `MAT_SIZE; i++) begin
        for (j = 0; j < `MAT_SIZE; j++) begin
          case (n)
            0: begin
              cases[n].a[i][j] = (i == j) ? elem_t'(1) : elem_t'(0);
              cases[n].b[i][j] = elem_t'(i * `MAT_SIZE + j + 1);
            end
            1: begin
              cases[n].a[i][j] = elem_t'(1);
              cases[n].b[i][j] = elem_t'(1);
            end
            // products and sums wrap
            2: begin
              cases[n].a[i][j] = 16'hffff;
              cases[n].b[i][j] = 16'hffff;
            end
            3: begin
              cases[n].a[i][j] = 16'hffff;
              cases[n].b[i][j] = elem_t'(i + j + 2);
            end
            default: begin
              random_elem(cases[n].a[i][j]);
              random_elem(cases[n].b[i][j]);
            end
          endcase
        end
      end
      cases[n].c = reference_product(cases[n].a, cases[n].b);
    end
  endtask

  ////////////////////
  // checks
  ////////////////////

  task automatic abort_run();
    $display("SOME TESTS FAILED");
    $fatal(1, "stopping at the first failure");
  endtask

  task automatic check_elem(input elem_t actual, input elem_t expected, input string what);
    if (actual !== expected) begin
      $display("Error at %0t: %s, expected %h, got %h", $time, what, expected, actual);
      abort_run();
    end
  endtask

  task automatic check_addr(input addr_t actual, input addr_t expected, input string what);
    if (actual !== expected) begin
      $display("Error at %0t: %s, expected %0d, got %0d", $time, what, expected, actual);
      abort_run();
    end
  endtask

  task automatic check_flag(input logic actual, input logic expected, input string what);
    if (actual !== expected) begin
      $display("Error at %0t: %s, expected %b, got %b", $time, what, expected, actual);
      abort_run();
    end
  endtask

  task automatic check_idle(input string where);
    int r;
    check_flag(done_mat_mul, 1'b0, {where, ": done"});
    check_addr(a_addr, addr_t'(`IDLE_ADDR), {where, ": a_addr"});
    check_addr(b_addr, addr_t'(`IDLE_ADDR), {where, ": b_addr"});
    for (r = 0; r < `MAT_SIZE; r++) begin
      check_elem(c_data[r*`ELEM_WIDTH +: `ELEM_WIDTH], '0,
                 $sformatf("%s: c_data lane %0d", where, r));
    end
  endtask

  ////////////////////
  // stimulus
  ////////////////////

  task automatic drive_start(input logic value);
    @(posedge clk);
    start_mat_mul <= value;
  endtask

  task automatic release_reset();
    repeat (3) @(posedge clk);
    reset <= 1'b0;
  endtask

  task automatic run_case(input int idx);
    int    cycle;
    int    m;
    int    r;
    addr_t exp_addr;
    logic  waiting;
    cur_case = cases[idx];
    drive_start(1'b1);
    // count 0 is the first cycle with start high
    cycle   = 0;
    waiting = 1'b1;
    while (waiting) begin
      @(negedge clk);
      if (cycle >= 1 && cycle <= `MAT_SIZE) begin
        exp_addr = addr_t'(cycle - 1);
      end else begin
        exp_addr = addr_t'(`IDLE_ADDR);
      end
      check_addr(a_addr, exp_addr, $sformatf("case %0d a_addr at count %0d", idx, cycle));
      check_addr(b_addr, exp_addr, $sformatf("case %0d b_addr at count %0d", idx, cycle));
      check_flag(done_mat_mul, cycle >= DONE_COUNT,
                 $sformatf("case %0d done at count %0d", idx, cycle));
      if (done_mat_mul) begin
        waiting = 1'b0;
      end else begin
        cycle++;
        if (cycle > DONE_TIMEOUT) begin
          $display("timeout: done_mat_mul never rose in case %0d", idx);
          abort_run();
        end
      end
    end
    // C leaves one column per cycle, row r r cycles late
    for (m = 0; m < DRAIN_CYCLES; m++) begin
      if (m > 0) begin
        @(negedge clk);
        check_flag(done_mat_mul, 1'b1,
                   $sformatf("case %0d done held at d0+%0d", idx, m));
        check_addr(a_addr, addr_t'(`IDLE_ADDR),
                   $sformatf("case %0d a_addr at d0+%0d", idx, m));
        check_addr(b_addr, addr_t'(`IDLE_ADDR),
                   $sformatf("case %0d b_addr at d0+%0d", idx, m));
      end
      for (r = 0; r < `MAT_SIZE; r++) begin
        check_elem(c_data[r*`ELEM_WIDTH +: `ELEM_WIDTH], drain_expect(cur_case.c, r, m),
                   $sformatf("case %0d c_data lane %0d at d0+%0d", idx, r, m));
      end
    end
    drive_start(1'b0);
    @(negedge clk);
    check_flag(done_mat_mul, 1'b1, $sformatf("case %0d done before start is seen low", idx));
    @(negedge clk);
    check_idle($sformatf("case %0d after start drop", idx));
    @(negedge clk);
    check_idle($sformatf("case %0d idle gap", idx));
  endtask

  initial begin
    int n;
    reset         = 1'b1;
    start_mat_mul = 1'b0;
    cur_case      = '0;
    lfsr_state    = 32'h86a6de86;
    build_cases();
    release_reset();
    repeat (3) begin
      @(negedge clk);
      check_idle("after reset");
    end
    for (n = 0; n < NUM_CASES; n++) begin
      run_case(n);
    end
    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

/* tb_matmul_4x4_systolic_sva.sv */
`timescale 1ns/1ps
`include "systolic_macros.svh"

module tb_matmul_4x4_systolic_sva
  import systolic_pkg::*;
(
  input logic  clk,
  input logic  reset,
  input logic  start_mat_mul,
  input addr_t a_addr,
  input addr_t b_addr,
  input logic  done_mat_mul
);

  // outputs parked one cycle after reset
  a_reset_idle: assert property (@(posedge clk)
    reset |=> !done_mat_mul && a_addr == addr_t'(`IDLE_ADDR) && b_addr == addr_t'(`IDLE_ADDR))
    else $error("outputs not idle in the cycle after reset");

  // dropping start ends the run at the next edge
  a_done_falls: assert property (@(posedge clk)
    !start_mat_mul |=> !done_mat_mul)
    else $error("done_mat_mul still high after start_mat_mul dropped");

  a_addr_match: assert property (@(posedge clk) disable iff (reset)
    a_addr == b_addr)
    else $error("a_addr and b_addr differ");

endmodule

bind matmul_4x4_systolic tb_matmul_4x4_systolic_sva u_sva (
  .clk           (clk),
  .reset         (reset),
  .start_mat_mul (start_mat_mul),
  .a_addr        (a_addr),
  .b_addr        (b_addr),
  .done_mat_mul  (done_mat_mul)
);

/* matmul_4x4_systolic.sv */
`timescale 1ns/1ps
`include "systolic_macros.svh"

module matmul_4x4_systolic
  import systolic_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  logic      start_mat_mul,
  input  lane_vec_t a_data,
  input  lane_vec_t b_data,
  output addr_t     a_addr,
  output addr_t     b_addr,
  output lane_vec_t c_data,
  output logic      done_mat_mul
);

  operand_t                   mem_operands;
  operand_t                   skewed_operands;
  logic                       flush;
  logic [`MAT_SIZE-1:0]       row_latch;
  lane_vec_t [`MAT_SIZE-1:0] acc_rows;

  ////////////////////
  // fetch control
  ////////////////////

  mac_sequencer u_seq (
    .clk           (clk),
    .reset         (reset),
    .start_mat_mul (start_mat_mul),
    .a_addr        (a_addr),
    .b_addr        (b_addr),
    .flush         (flush),
    .row_latch     (row_latch),
    .done_mat_mul  (done_mat_mul)
  );

  // A column k and B row k arrive together from the async memories
  assign mem_operands = '{a_lanes: a_data, b_lanes: b_data};

  ////////////////////
  // datapath
  ////////////////////

  operand_skew u_skew (
    .clk          (clk),
    .reset        (reset),
    .flush        (flush),
    .operands_in  (mem_operands),
    .operands_out (skewed_operands)
  );

  pe_array u_array (
    .clk      (clk),
    .reset    (reset),
    .flush    (flush),
    .operands (skewed_operands),
    .acc_rows (acc_rows)
  );

  result_drain u_drain (
    .clk       (clk),
    .reset     (reset),
    .row_latch (row_latch),
    .acc_rows  (acc_rows),
    .c_data    (c_data)
  );

endmodule

/* result_drain.sv */
`timescale 1ns/1ps
`include "systolic_macros.svh"

module result_drain
  import systolic_pkg::*;
(
  input  logic                       clk,
  input  logic                       reset,
  input  logic [`MAT_SIZE-1:0]       row_latch,
  input  lane_vec_t [`MAT_SIZE-1:0] acc_rows,
  output lane_vec_t                  c_data
);

  lane_vec_t row_q [`MAT_SIZE];

  ////////////////////
  // row shifters
  ////////////////////

  // capture on the strobe, otherwise move one element toward lane 0
  for (genvar r = 0; r < `MAT_SIZE; r++) begin : g_row
    always_ff @(posedge clk) begin
      if (reset) begin
        row_q[r] <= '0;
      end else if (row_latch[r]) begin
        row_q[r] <= acc_rows[r];
      end else begin
        row_q[r] <= {{`ELEM_WIDTH{1'b0}},
                     row_q[r][`MAT_SIZE*`ELEM_WIDTH-1:`ELEM_WIDTH]};
      end
    end
  end

  ////////////////////
  // output lanes
  ////////////////////

  // lane r carries the low element of row r
  always_comb begin
    for (int r = 0; r < `MAT_SIZE; r++) begin
      c_data[r*`ELEM_WIDTH +: `ELEM_WIDTH] = row_q[r][`ELEM_WIDTH-1:0];
    end
  end

endmodule

/* pe_array.sv */
`timescale 1ns/1ps
`include "systolic_macros.svh"

module pe_array
  import systolic_pkg::*;
(
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       flush,
  input  operand_t                   operands,
  output lane_vec_t [`MAT_SIZE-1:0] acc_rows
);

  // a_link[i][j] enters cell (i,j) from the left, b_link[i][j] from above
  elem_t a_link   [`MAT_SIZE][`MAT_SIZE+1];
  elem_t b_link   [`MAT_SIZE+1][`MAT_SIZE];
  elem_t acc_cell [`MAT_SIZE][`MAT_SIZE];

  for (genvar i = 0; i < `MAT_SIZE; i++) begin : g_edge
    assign a_link[i][0] = operands.a_lanes[i*`ELEM_WIDTH +: `ELEM_WIDTH];
    assign b_link[0][i] = operands.b_lanes[i*`ELEM_WIDTH +: `ELEM_WIDTH];
  end

  for (genvar i = 0; i < `MAT_SIZE; i++) begin : g_row
    for (genvar j = 0; j < `MAT_SIZE; j++) begin : g_col
      processing_element u_pe (
        .clk   (clk),
        .reset (reset),
        .flush (flush),
        .in_a  (a_link[i][j]),
        .in_b  (b_link[i][j]),
        .out_a (a_link[i][j+1]),
        .out_b (b_link[i+1][j]),
        .acc   (acc_cell[i][j])
      );
    end
  end

  // cell (i,j) lands in lane j of row i
  always_comb begin
    for (int i = 0; i < `MAT_SIZE; i++) begin
      for (int j = 0; j < `MAT_SIZE; j++) begin
        acc_rows[i][j*`ELEM_WIDTH +: `ELEM_WIDTH] = acc_cell[i][j];
      end
    end
  end

endmodule

/* processing_element.sv */
`timescale 1ns/1ps

module processing_element
  import systolic_pkg::*;
(
  input  logic  clk,
  input  logic  reset,
  input  logic  flush,
  input  elem_t in_a,
  input  elem_t in_b,
  output elem_t out_a,
  output elem_t out_b,
  output elem_t acc
);

  // operands move on to the right and lower neighbours one cycle later
  always_ff @(posedge clk) begin
    if (reset) begin
      out_a <= '0;
      out_b <= '0;
    end else begin
      out_a <= in_a;
      out_b <= in_b;
    end
  end

  // single cycle MAC, sum wraps at ELEM_WIDTH bits
  always_ff @(posedge clk) begin
    if (reset || flush) begin
      acc <= '0;
    end else begin
      acc <= acc + in_a * in_b;
    end
  end

endmodule

/* operand_skew.sv */
`timescale 1ns/1ps
`include "systolic_macros.svh"

module operand_skew
  import systolic_pkg::*;
(
  input  logic     clk,
  input  logic     reset,
  input  logic     flush,
  input  operand_t operands_in,
  output operand_t operands_out
);

  elem_t a_tap [`MAT_SIZE];
  elem_t b_tap [`MAT_SIZE];

  // lane i goes through i registers so the array sees a diagonal wavefront
  for (genvar i = 0; i < `MAT_SIZE; i++) begin : g_lane
    if (i == 0) begin : g_pass
      assign a_tap[i] = operands_in.a_lanes[0 +: `ELEM_WIDTH];
      assign b_tap[i] = operands_in.b_lanes[0 +: `ELEM_WIDTH];
    end else begin : g_delay
      elem_t a_dly [i];
      elem_t b_dly [i];

      always_ff @(posedge clk) begin
        if (reset || flush) begin
          for (int d = 0; d < i; d++) begin
            a_dly[d] <= '0;
            b_dly[d] <= '0;
          end
        end else begin
          a_dly[0] <= operands_in.a_lanes[i*`ELEM_WIDTH +: `ELEM_WIDTH];
          b_dly[0] <= operands_in.b_lanes[i*`ELEM_WIDTH +: `ELEM_WIDTH];
          for (int d = 1; d < i; d++) begin
            a_dly[d] <= a_dly[d-1];
            b_dly[d] <= b_dly[d-1];
          end
        end
      end

      assign a_tap[i] = a_dly[i-1];
      assign b_tap[i] = b_dly[i-1];
    end
  end

  always_comb begin
    for (int i = 0; i < `MAT_SIZE; i++) begin
      operands_out.a_lanes[i*`ELEM_WIDTH +: `ELEM_WIDTH] = a_tap[i];
      operands_out.b_lanes[i*`ELEM_WIDTH +: `ELEM_WIDTH] = b_tap[i];
    end
  end

endmodule

/* mac_sequencer.sv */
`timescale 1ns/1ps
`include "systolic_macros.svh"

module mac_sequencer
  import systolic_pkg::*;
(
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 start_mat_mul,
  output addr_t                a_addr,
  output addr_t                b_addr,
  output logic                 flush,
  output logic [`MAT_SIZE-1:0] row_latch,
  output logic                 done_mat_mul
);

  seq_state_t           state;
  count_t               count;
  addr_t                rd_addr;
  logic [`MAT_SIZE-1:1] latch_dly;

  ////////////////////
  // run FSM
  ////////////////////

  // count 0 is the first cycle with start high, spent in IDLE
  always_ff @(posedge clk) begin
    if (reset || !start_mat_mul) begin
      state <= IDLE;
      count <= '0;
    end else begin
      case (state)
        IDLE: begin
          state <= RUN;
          count <= count + 5'd1;
        end
        RUN: begin
          count <= count + 5'd1;
          if (count == count_t'(`LATCH_CYCLE)) begin
            state <= DONE;
          end
        end
        // counter frozen, done held until start drops
        default: state <= DONE;
      endcase
    end
  end

  // address k shows up during count k+1
  always_ff @(posedge clk) begin
    if (reset || !start_mat_mul) begin
      rd_addr <= addr_t'(`IDLE_ADDR);
    end else if (count < count_t'(`MAT_SIZE)) begin
      rd_addr <= addr_t'(count);
    end else begin
      rd_addr <= addr_t'(`IDLE_ADDR);
    end
  end

  // rows finish one cycle apart, so the strobe ripples down
  always_ff @(posedge clk) begin
    if (flush) begin
      latch_dly <= '0;
    end else begin
      latch_dly <= row_latch[`MAT_SIZE-2:0];
    end
  end

  assign row_latch    = {latch_dly, count == count_t'(`LATCH_CYCLE)};
  assign flush        = reset || !start_mat_mul || (count == '0);
  assign done_mat_mul = (state == DONE);
  assign a_addr       = rd_addr;
  assign b_addr       = rd_addr;

endmodule

/* systolic_pkg.sv */
`include "systolic_macros.svh"

package systolic_pkg;

  // one matrix element
  typedef logic [`ELEM_WIDTH-1:0] elem_t;

  // MAT_SIZE elements side by side, lane 0 in the low bits
  typedef logic [`MAT_SIZE*`ELEM_WIDTH-1:0] lane_vec_t;

  typedef logic [`ADDR_WIDTH-1:0] addr_t;

  // run counter, holds at LATCH_CYCLE+1 once the run is done
  typedef logic [4:0] count_t;

  // A column and B row fetched in the same cycle
  typedef struct packed {
    lane_vec_t a_lanes;
    lane_vec_t b_lanes;
  } operand_t;

  typedef enum logic [1:0] {
    IDLE,
    RUN,
    DONE
  } seq_state_t;

endpackage

/* systolic_macros.svh */
`ifndef SYSTOLIC_MACROS_SVH
`define SYSTOLIC_MACROS_SVH

////////////////////
// array geometry
////////////////////

// width of one matrix element, products wrap at this width
`define ELEM_WIDTH 16

// matrix dimension, also the number of operand lanes
`define MAT_SIZE 4

////////////////////
// operand memory
////////////////////

`define ADDR_WIDTH 7

// top of the 128 entry memory, parked here between runs
`define IDLE_ADDR 127

// count at which row 0 of the accumulators is final
`define LATCH_CYCLE 8

`endif
